//--- clk_switch_top.f
rtl/clk_switch_pkg.sv
rtl/clk_switch_regs.sv
rtl/clk_switch_fsm.sv
rtl/clk_fail_monitor.sv
rtl/glitch_free_clk_switch.sv
rtl/clk_switch_top.sv
test/tb_clk_switch.sv

//--- rtl/clk_fail_monitor.sv
`timescale 1ns/100ps

module clk_fail_monitor #(
  parameter int CLK_NUM       = 4,
  parameter int WINDOW_CYCLES = 64,
  parameter int MIN_EDGES     = 2
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [CLK_NUM-1:0] i_clk,
  output logic [CLK_NUM-1:0] clk_fail,
  output logic [CLK_NUM-1:0] src_rst_n
);

  localparam int tmr_w = $clog2(WINDOW_CYCLES);
  localparam int cnt_w = $clog2(MIN_EDGES + 1);

  logic [tmr_w-1:0] timer;
  logic             window_end;

  // ==============================
  // window timer
  // ==============================
  assign window_end = (timer == tmr_w'(WINDOW_CYCLES - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      timer <= '0;
    end else if (window_end) begin
      timer <= '0;
    end else begin
      timer <= timer + 1'b1;
    end
  end

  // ==============================
  // per-source logic
  // ==============================
  for (genvar k = 0; k < CLK_NUM; k++) begin : g_src
    logic [1:0]       rst_sync;
    logic             toggle;
    logic [2:0]       tog_sync;
    logic             edge_seen;
    logic [cnt_w-1:0] edge_cnt;
    logic             fail_q;

    // reset into the source domain
    // assertion is immediate so a stopped source still enters reset
    always_ff @(posedge i_clk[k] or negedge rst_n) begin
      if (!rst_n) begin
        rst_sync <= 2'b00;
      end else begin
        rst_sync <= {rst_sync[0], 1'b1};
      end
    end
    assign src_rst_n[k] = rst_sync[1];

    // flips once per source edge
    always_ff @(posedge i_clk[k]) begin
      if (!src_rst_n[k]) begin
        toggle <= 1'b0;
      end else begin
        toggle <= ~toggle;
      end
    end

    // three flops into clk, compare the last two
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        tog_sync <= '0;
      end else begin
        tog_sync <= {tog_sync[1:0], toggle};
      end
    end
    assign edge_seen = tog_sync[2] ^ tog_sync[1];

    // saturating edge count, judged at window end
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        edge_cnt <= '0;
        fail_q   <= 1'b0;
      end else if (window_end) begin
        fail_q   <= (edge_cnt < MIN_EDGES);
        edge_cnt <= '0;
      end else if (edge_seen && edge_cnt < MIN_EDGES) begin
        edge_cnt <= edge_cnt + 1'b1;
      end
    end
    assign clk_fail[k] = fail_q;
  end

  a_timer_range : assert property (@(posedge clk) disable iff (!rst_n)
    timer <= tmr_w'(WINDOW_CYCLES - 1));

endmodule

//--- rtl/clk_switch_fsm.sv
`timescale 1ns/100ps

module clk_switch_fsm #(
  parameter int CLK_NUM       = 4,
  parameter int SETTLE_CYCLES = 32
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  clk_switch_pkg::ctrl_word_u ctrl_word,
  input  logic                       ctrl_update,
  input  logic [CLK_NUM-1:0]         clk_fail,
  output logic [$clog2(CLK_NUM)-1:0] sel,
  output clk_switch_pkg::fsm_state_e state
);

  localparam int sel_w = $clog2(CLK_NUM);
  localparam int cnt_w = $clog2(SETTLE_CYCLES + 1);

  logic [sel_w-1:0] desired_sel;
  logic             desired_valid;
  logic             pending;
  logic             eval;
  logic [cnt_w-1:0] settle_cnt;
  logic             settle_done;

  // ==============================
  // desired source
  // ==============================
  always_comb begin
    desired_valid = 1'b0;
    desired_sel   = '0;
    if (!ctrl_word.manual_view.mode) begin
      // manual, an index past CLK_NUM has no clock
      if (ctrl_word.manual_view.src_idx < CLK_NUM) begin
        desired_sel   = ctrl_word.manual_view.src_idx[sel_w-1:0];
        desired_valid = !clk_fail[desired_sel];
      end
    end else begin
      // auto, scan downward so the lowest running index wins
      for (int k = CLK_NUM - 1; k >= 0; k--) begin
        if (ctrl_word.auto_view.src_mask[k] && !clk_fail[k]) begin
          desired_valid = 1'b1;
          desired_sel   = sel_w'(k);
        end
      end
    end
  end

  // re-evaluate only outside switching
  always_comb begin
    case (state)
      clk_switch_pkg::idle:     eval = pending | ctrl_update;
      clk_switch_pkg::settled:  eval = pending | ctrl_update | !desired_valid |
                                       (desired_sel != sel);
      clk_switch_pkg::no_clock: eval = pending | ctrl_update | desired_valid;
      default:                  eval = 1'b0;
    endcase
  end

  assign settle_done = (settle_cnt == cnt_w'(SETTLE_CYCLES - 1));

  // ==============================
  // state and selection
  // ==============================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= clk_switch_pkg::idle;
      sel        <= '0;
      settle_cnt <= '0;
      pending    <= 1'b0;
    end else begin
      // a write during switching waits here until settle
      pending <= (pending | ctrl_update) & ~eval;
      if (eval) begin
        if (desired_valid) begin
          state      <= clk_switch_pkg::switching;
          sel        <= desired_sel;
          settle_cnt <= '0;
        end else begin
          // sel held, the switch drops a failed source on its own
          state <= clk_switch_pkg::no_clock;
        end
      end else if (state == clk_switch_pkg::switching) begin
        if (settle_done) begin
          state <= clk_switch_pkg::settled;
        end else begin
          settle_cnt <= settle_cnt + 1'b1;
        end
      end
    end
  end

  // the switch only sees a new sel at the start of a settle period
  a_sel_on_switch : assert property (@(posedge clk) disable iff (!rst_n)
    !$stable(sel) |-> state == clk_switch_pkg::switching &&
                      $past(state) != clk_switch_pkg::switching);

endmodule

//--- rtl/clk_switch_pkg.sv
package clk_switch_pkg;

  // ==============================
  // axi4-lite geometry
  // ==============================
  localparam int addr_w = 4;
  localparam int data_w = 32;

  // register map, byte offsets
  localparam logic [addr_w-1:0] ctrl_addr   = 4'h0;
  localparam logic [addr_w-1:0] status_addr = 4'h4;

  // bresp / rresp codes
  localparam logic [1:0] axi_resp_okay   = 2'b00;
  localparam logic [1:0] axi_resp_slverr = 2'b10;

  // largest source count the control fields can address
  localparam int max_clk_num = 8;
  localparam int idx_w       = $clog2(max_clk_num);

  // ==============================
  // control word
  // ==============================
  // bit 31 picks manual (0) or auto (1)
  // manual view carries a source index, auto view a source mask
  typedef union packed {
    struct packed {
      logic                    mode;
      logic [data_w-idx_w-2:0] rsvd;
      logic [idx_w-1:0]        src_idx;
    } manual_view;
    struct packed {
      logic                          mode;
      logic [data_w-max_clk_num-2:0] rsvd;
      logic [max_clk_num-1:0]        src_mask;
    } auto_view;
  } ctrl_word_u;

  // selection fsm states, also reported in status[5:4]
  typedef enum logic [1:0] {
    idle      = 2'd0,
    switching = 2'd1,
    settled   = 2'd2,
    no_clock  = 2'd3
  } fsm_state_e;

endpackage

//--- rtl/clk_switch_regs.sv
`timescale 1ns/100ps

module clk_switch_regs #(
  parameter int CLK_NUM = 4
) (
  input  logic                               clk,
  input  logic                               rst_n,
  // write address / data / response
  input  logic [clk_switch_pkg::addr_w-1:0]  s_awaddr,
  input  logic                               s_awvalid,
  output logic                               s_awready,
  input  logic [clk_switch_pkg::data_w-1:0]  s_wdata,
  input  logic                               s_wvalid,
  output logic                               s_wready,
  output logic [1:0]                         s_bresp,
  output logic                               s_bvalid,
  input  logic                               s_bready,
  // read address / data
  input  logic [clk_switch_pkg::addr_w-1:0]  s_araddr,
  input  logic                               s_arvalid,
  output logic                               s_arready,
  output logic [clk_switch_pkg::data_w-1:0]  s_rdata,
  output logic [1:0]                         s_rresp,
  output logic                               s_rvalid,
  input  logic                               s_rready,
  // status inputs
  input  logic [$clog2(CLK_NUM)-1:0]         cur_sel,
  input  clk_switch_pkg::fsm_state_e         state,
  input  logic [CLK_NUM-1:0]                 fail_mask,
  // control to the fsm
  output clk_switch_pkg::ctrl_word_u         ctrl_word,
  output logic                               ctrl_update
);

  localparam int sel_w = $clog2(CLK_NUM);

  logic                              wr_go;
  logic                              wr_hs;
  logic                              rd_go;
  logic                              rd_hs;
  logic [clk_switch_pkg::data_w-1:0] status_word;

  // start a write only when both channels are valid and no response is owed
  assign wr_go = s_awvalid & s_wvalid & ~s_awready & ~s_bvalid;
  assign wr_hs = s_awready & s_awvalid & s_wvalid;
  // one read in flight at a time
  assign rd_go = s_arvalid & ~s_arready & ~s_rvalid;
  assign rd_hs = s_arready & s_arvalid;

  // status layout
  // sel in [2:0], state in [5:4], fail flags from bit 8
  always_comb begin
    status_word                = '0;
    status_word[sel_w-1:0]     = cur_sel;
    status_word[5:4]           = state;
    status_word[8 +: CLK_NUM]  = fail_mask;
  end

  // ==============================
  // write path
  // ==============================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s_awready   <= 1'b0;
      s_wready    <= 1'b0;
      s_bvalid    <= 1'b0;
      ctrl_word   <= '0;
      ctrl_update <= 1'b0;
    end else begin
      // ready is a single-cycle pulse
      s_awready   <= wr_go;
      s_wready    <= wr_go;
      ctrl_update <= 1'b0;
      if (wr_hs) begin
        s_bvalid <= 1'b1;
        if (s_awaddr == clk_switch_pkg::ctrl_addr) begin
          ctrl_word   <= s_wdata;
          ctrl_update <= 1'b1;
        end
      end else if (s_bvalid && s_bready) begin
        s_bvalid <= 1'b0;
      end
    end
  end

  // response code, held with bvalid
  always_ff @(posedge clk) begin
    if (wr_hs) begin
      // status writes are dropped without error
      if (s_awaddr == clk_switch_pkg::ctrl_addr || s_awaddr == clk_switch_pkg::status_addr) begin
        s_bresp <= clk_switch_pkg::axi_resp_okay;
      end else begin
        s_bresp <= clk_switch_pkg::axi_resp_slverr;
      end
    end
  end

  // ==============================
  // read path
  // ==============================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s_arready <= 1'b0;
      s_rvalid  <= 1'b0;
    end else begin
      s_arready <= rd_go;
      if (rd_hs) begin
        s_rvalid <= 1'b1;
      end else if (s_rvalid && s_rready) begin
        s_rvalid <= 1'b0;
      end
    end
  end

  // read data sampled at the address handshake
  always_ff @(posedge clk) begin
    if (rd_hs) begin
      if (s_araddr == clk_switch_pkg::ctrl_addr) begin
        s_rdata <= ctrl_word;
        s_rresp <= clk_switch_pkg::axi_resp_okay;
      end else if (s_araddr == clk_switch_pkg::status_addr) begin
        s_rdata <= status_word;
        s_rresp <= clk_switch_pkg::axi_resp_okay;
      end else begin
        s_rdata <= '0;
        s_rresp <= clk_switch_pkg::axi_resp_slverr;
      end
    end
  end

  // a write response is never withdrawn before the master takes it
  a_bvalid_hold : assert property (@(posedge clk) disable iff (!rst_n)
    s_bvalid && !s_bready |=> s_bvalid);

endmodule

//--- rtl/clk_switch_top.sv
`timescale 1ns/100ps

module clk_switch_top #(
  parameter int CLK_NUM       = 4,
  parameter int WINDOW_CYCLES = 64,
  parameter int MIN_EDGES     = 2,
  parameter int SETTLE_CYCLES = 32
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic [clk_switch_pkg::addr_w-1:0] s_awaddr,
  input  logic                              s_awvalid,
  output logic                              s_awready,
  input  logic [clk_switch_pkg::data_w-1:0] s_wdata,
  input  logic                              s_wvalid,
  output logic                              s_wready,
  output logic [1:0]                        s_bresp,
  output logic                              s_bvalid,
  input  logic                              s_bready,
  input  logic [clk_switch_pkg::addr_w-1:0] s_araddr,
  input  logic                              s_arvalid,
  output logic                              s_arready,
  output logic [clk_switch_pkg::data_w-1:0] s_rdata,
  output logic [1:0]                        s_rresp,
  output logic                              s_rvalid,
  input  logic                              s_rready,
  input  logic [CLK_NUM-1:0]                i_clk,
  input  logic                              scan_mode,
  input  logic                              test_clk,
  output logic                              o_clk
);

  clk_switch_pkg::ctrl_word_u ctrl_word;
  logic                       ctrl_update;
  clk_switch_pkg::fsm_state_e state;
  logic [$clog2(CLK_NUM)-1:0] sel;
  logic [CLK_NUM-1:0]         clk_fail;
  logic [CLK_NUM-1:0]         src_rst_n;

  // register port
  clk_switch_regs #(
    .CLK_NUM (CLK_NUM)
  ) u_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .s_awaddr    (s_awaddr),
    .s_awvalid   (s_awvalid),
    .s_awready   (s_awready),
    .s_wdata     (s_wdata),
    .s_wvalid    (s_wvalid),
    .s_wready    (s_wready),
    .s_bresp     (s_bresp),
    .s_bvalid    (s_bvalid),
    .s_bready    (s_bready),
    .s_araddr    (s_araddr),
    .s_arvalid   (s_arvalid),
    .s_arready   (s_arready),
    .s_rdata     (s_rdata),
    .s_rresp     (s_rresp),
    .s_rvalid    (s_rvalid),
    .s_rready    (s_rready),
    .cur_sel     (sel),
    .state       (state),
    .fail_mask   (clk_fail),
    .ctrl_word   (ctrl_word),
    .ctrl_update (ctrl_update)
  );

  // source selection
  clk_switch_fsm #(
    .CLK_NUM       (CLK_NUM),
    .SETTLE_CYCLES (SETTLE_CYCLES)
  ) u_fsm (
    .clk         (clk),
    .rst_n       (rst_n),
    .ctrl_word   (ctrl_word),
    .ctrl_update (ctrl_update),
    .clk_fail    (clk_fail),
    .sel         (sel),
    .state       (state)
  );

  // stopped-clock detection
  clk_fail_monitor #(
    .CLK_NUM       (CLK_NUM),
    .WINDOW_CYCLES (WINDOW_CYCLES),
    .MIN_EDGES     (MIN_EDGES)
  ) u_monitor (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_clk     (i_clk),
    .clk_fail  (clk_fail),
    .src_rst_n (src_rst_n)
  );

  // glitch-free mux
  glitch_free_clk_switch #(
    .CLK_NUM (CLK_NUM)
  ) u_switch (
    .i_clk     (i_clk),
    .clk_fail  (clk_fail),
    .sel       (sel),
    .rst_n     (src_rst_n),
    .scan_mode (scan_mode),
    .test_clk  (test_clk),
    .o_clk     (o_clk)
  );

endmodule

//--- rtl/glitch_free_clk_switch.sv
`timescale 1ns/100ps

module glitch_free_clk_switch #(
  parameter int CLK_NUM = 4
) (
  input  logic [CLK_NUM-1:0]         i_clk,
  input  logic [CLK_NUM-1:0]         clk_fail,
  input  logic [$clog2(CLK_NUM)-1:0] sel,
  input  logic [CLK_NUM-1:0]         rst_n,
  input  logic                       scan_mode,
  input  logic                       test_clk,
  output logic                       o_clk
);

  localparam int sel_w = $clog2(CLK_NUM);

  logic [CLK_NUM-1:0] onehot_sel;
  logic [CLK_NUM-1:0] clk_sel;
  logic [CLK_NUM-1:0] clk_sel_ff;
  logic [CLK_NUM-1:0] clk_pre_out;
  logic [CLK_NUM-1:0] clk_rst_n;
  logic               raw_o_clk;

  // a failed source is held in reset so its enable clears
  assign clk_rst_n = rst_n & ~clk_fail;

  // ==============================
  // per-source enable chain
  // ==============================
  for (genvar k = 0; k < CLK_NUM; k++) begin : g_src
    localparam logic [CLK_NUM-1:0] self_bit = CLK_NUM'(1) << k;

    logic en_f;
    logic en_ff;

    // one-hot decode of sel
    assign onehot_sel[k] = (sel == sel_w'(k));

    // request only while every other source is off
    assign clk_sel[k] = onehot_sel[k] & ~(|(clk_sel_ff & ~self_bit));

    // two flops on the falling source edge
    // clear is asynchronous since a dead source gives no edge to clear on
    always_ff @(negedge i_clk[k] or negedge clk_rst_n[k]) begin
      if (!clk_rst_n[k]) begin
        en_f  <= 1'b0;
        en_ff <= 1'b0;
      end else begin
        en_f  <= clk_sel[k];
        en_ff <= en_f;
      end
    end
    assign clk_sel_ff[k] = en_ff;

    // enable changes while the source is low, so each high phase passes whole
    assign clk_pre_out[k] = i_clk[k] & en_ff;

    // the handover never overlaps two sources
    a_one_enable : assert property (@(posedge i_clk[k]) disable iff (!clk_rst_n[k])
      $onehot0(clk_sel_ff));
  end

  // ==============================
  // output
  // ==============================
  assign raw_o_clk = |clk_pre_out;

  // scan bypass
  assign o_clk = scan_mode ? test_clk : raw_o_clk;

endmodule

//--- test/tb_clk_switch.sv
`timescale 1ns/100ps

module tb_clk_switch;

  localparam int clk_num     = 4;
  localparam int test_period = 12;
  localparam int no_clk_idx  = -1;
  localparam int poll_limit  = 400;
  localparam int edge_limit  = 250;

  // status fields
  localparam logic [31:0] state_field = 32'h0000_0030;
  localparam logic [31:0] fail_field  = 32'h0000_0f00;

  logic                              clk = 1'b0;
  logic                              rst_n;
  logic [clk_switch_pkg::addr_w-1:0] s_awaddr;
  logic                              s_awvalid;
  logic                              s_awready;
  logic [clk_switch_pkg::data_w-1:0] s_wdata;
  logic                              s_wvalid;
  logic                              s_wready;
  logic [1:0]                        s_bresp;
  logic                              s_bvalid;
  logic                              s_bready;
  logic [clk_switch_pkg::addr_w-1:0] s_araddr;
  logic                              s_arvalid;
  logic                              s_arready;
  logic [clk_switch_pkg::data_w-1:0] s_rdata;
  logic [1:0]                        s_rresp;
  logic                              s_rvalid;
  logic                              s_rready;
  wire  [clk_num-1:0]                i_clk;
  logic [clk_num-1:0]                src_en;
  logic                              scan_mode;
  logic                              test_clk = 1'b0;
  wire                               o_clk;

  int      errors      = 0;
  int      checks      = 0;
  int      tests       = 0;
  int      oclk_edges  = 0;
  realtime last_edge_t = 0.0;

  // source periods are 20, 28, 36 and 44 ns
  function automatic int src_period_ns(input int k);
    return 20 + 8 * k;
  endfunction

  // ==============================
  // clocks
  // ==============================
  always #2 clk = ~clk;

  // sources start off phase so no edge lands on a clk edge
  for (genvar k = 0; k < clk_num; k++) begin : g_src
    logic src_clk;

    assign i_clk[k] = src_clk;

    initial begin
      src_clk = 1'b0;
      #(0.3 + 0.2 * k);
      forever begin
        #(src_period_ns(k) / 2.0);
        // a stopped source parks low
        src_clk = src_en[k] ? ~src_clk : 1'b0;
      end
    end
  end

  initial begin
    #1.1;
    forever #(test_period / 2.0) test_clk = ~test_clk;
  end

  // edge count and time stamp of the last o_clk rise
  always @(posedge o_clk) begin
    oclk_edges  = oclk_edges + 1;
    last_edge_t = $realtime;
  end

  clk_switch_top #(
    .CLK_NUM (clk_num)
  ) u_clk_switch_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .s_awaddr  (s_awaddr),
    .s_awvalid (s_awvalid),
    .s_awready (s_awready),
    .s_wdata   (s_wdata),
    .s_wvalid  (s_wvalid),
    .s_wready  (s_wready),
    .s_bresp   (s_bresp),
    .s_bvalid  (s_bvalid),
    .s_bready  (s_bready),
    .s_araddr  (s_araddr),
    .s_arvalid (s_arvalid),
    .s_arready (s_arready),
    .s_rdata   (s_rdata),
    .s_rresp   (s_rresp),
    .s_rvalid  (s_rvalid),
    .s_rready  (s_rready),
    .i_clk     (i_clk),
    .scan_mode (scan_mode),
    .test_clk  (test_clk),
    .o_clk     (o_clk)
  );

  // ==============================
  // reference and checking
  // ==============================
  // manual takes field[2:0] as an index, auto takes field as a mask
  function automatic int expected_sel(input logic mode, input logic [7:0] field,
                                      input logic [clk_num-1:0] failed);
    int idx;
    idx = no_clk_idx;
    if (!mode) begin
      if (field[2:0] < clk_num) begin
        if (!failed[field[2:0]]) idx = field[2:0];
      end
    end else begin
      // first allowed running source in ascending order
      for (int k = 0; k < clk_num; k++) begin
        if (idx == no_clk_idx && field[k] && !failed[k]) idx = k;
      end
    end
    return idx;
  endfunction

  task automatic check_value(input string name, input longint actual, input longint expected,
                             input longint tol);
    longint diff;
    diff = actual - expected;
    if (diff < 0) diff = -diff;
    checks = checks + 1;
    if (diff > tol) begin
      errors = errors + 1;
      $display("error: t=%0t %s got %0d expected %0d", $time, name, actual, expected);
    end
  endtask

  task automatic report_timeout(input string what);
    errors = errors + 1;
    $display("timeout at t=%0t: %s never happened", $time, what);
  endtask

  task automatic end_test(input string name, input int err_mark);
    tests = tests + 1;
    $display("test %-14s %s", name, (errors == err_mark) ? "ok" : "FAILED");
  endtask

  // ==============================
  // axi4-lite master
  // ==============================
  // all tasks start and end 1 ns after a rising clk edge
  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    int waited;
    resp      = 2'bxx;
    s_awaddr  = addr;
    s_wdata   = data;
    s_awvalid = 1'b1;
    s_wvalid  = 1'b1;
    waited    = 0;
    // ready is a one-cycle pulse, the handshake is on the following edge
    while (!s_awready && waited < edge_limit) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!s_awready) begin
      s_awvalid = 1'b0;
      s_wvalid  = 1'b0;
      report_timeout("write address accept");
      return;
    end
    @(posedge clk);
    #1;
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    waited    = 0;
    while (!s_bvalid && waited < edge_limit) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!s_bvalid) begin
      report_timeout("write response");
      return;
    end
    resp     = s_bresp;
    s_bready = 1'b1;
    @(posedge clk);
    #1;
    s_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int waited;
    data      = 'x;
    resp      = 2'bxx;
    s_araddr  = addr;
    s_arvalid = 1'b1;
    waited    = 0;
    while (!s_arready && waited < edge_limit) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!s_arready) begin
      s_arvalid = 1'b0;
      report_timeout("read address accept");
      return;
    end
    @(posedge clk);
    #1;
    s_arvalid = 1'b0;
    waited    = 0;
    while (!s_rvalid && waited < edge_limit) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!s_rvalid) begin
      report_timeout("read data");
      return;
    end
    data     = s_rdata;
    resp     = s_rresp;
    s_rready = 1'b1;
    @(posedge clk);
    #1;
    s_rready = 1'b0;
  endtask

  // poll status until the masked bits match
  task automatic wait_status(input logic [31:0] field, input logic [31:0] want,
                             input string what, output logic [31:0] status);
    logic [1:0] resp;
    int         polls;
    polls = 0;
    axi_read(clk_switch_pkg::status_addr, status, resp);
    while ((status & field) != want && polls < poll_limit) begin
      axi_read(clk_switch_pkg::status_addr, status, resp);
      polls++;
    end
    if ((status & field) != want) report_timeout(what);
  endtask

  // average o_clk period in ns, 0 when the clock is missing
  task automatic measure_period(output int period_ns);
    int      start_cnt;
    int      waited;
    realtime t0;
    period_ns = 0;
    // skip edges that may still belong to a handover
    start_cnt = oclk_edges;
    waited    = 0;
    while (oclk_edges < start_cnt + 4 && waited < edge_limit) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (oclk_edges < start_cnt + 4) return;
    t0        = last_edge_t;
    start_cnt = oclk_edges;
    waited    = 0;
    while (oclk_edges < start_cnt + 3 && waited < edge_limit) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (oclk_edges < start_cnt + 3) return;
    period_ns = $rtoi((last_edge_t - t0) / (oclk_edges - start_cnt) + 0.5);
  endtask

  // ==============================
  // test sequence
  // ==============================
  initial begin
    logic [1:0]         resp;
    logic [31:0]        rdata;
    logic [31:0]        status;
    logic [31:0]        wdata;
    logic [3:0]         mask;
    logic [clk_num-1:0] stopped;
    logic [1:0]         exp_state;
    int                 idx;
    int                 exp_idx;
    int                 period;
    int                 err_mark;

    void'($urandom(81269));
    rst_n     = 1'b0;
    s_awaddr  = '0;
    s_awvalid = 1'b0;
    s_wdata   = '0;
    s_wvalid  = 1'b0;
    s_bready  = 1'b0;
    s_araddr  = '0;
    s_arvalid = 1'b0;
    s_rready  = 1'b0;
    src_en    = '1;
    scan_mode = 1'b0;
    stopped   = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // register access
    err_mark = errors;
    wdata    = $urandom;
    axi_write(clk_switch_pkg::ctrl_addr, wdata, resp);
    check_value("bresp ctrl", resp, clk_switch_pkg::axi_resp_okay, 0);
    axi_read(clk_switch_pkg::ctrl_addr, rdata, resp);
    check_value("rresp ctrl", resp, clk_switch_pkg::axi_resp_okay, 0);
    check_value("rdata ctrl", rdata, wdata, 0);
    axi_read(4'h8, rdata, resp);
    check_value("rresp unmapped", resp, clk_switch_pkg::axi_resp_slverr, 0);
    check_value("rdata unmapped", rdata, 0, 0);
    axi_write(4'hc, 32'h1, resp);
    check_value("bresp unmapped", resp, clk_switch_pkg::axi_resp_slverr, 0);
    // let the random word play out, settled or no_clock both have bit 5
    wait_status(32'h20, 32'h20, "state leaving switching", status);
    end_test("registers", err_mark);

    // manual switching
    err_mark = errors;
    repeat (4) begin
      idx = $urandom_range(0, clk_num - 1);
      axi_write(clk_switch_pkg::ctrl_addr, 32'(idx), resp);
      wait_status(state_field, {26'd0, clk_switch_pkg::settled, 4'd0},
                  "settled after manual write", status);
      exp_idx = expected_sel(1'b0, 8'(idx), stopped);
      check_value("cur_sel", status[2:0], exp_idx, 0);
      measure_period(period);
      check_value("o_clk period", period, src_period_ns(exp_idx), 1);
    end
    end_test("manual", err_mark);

    // auto failover, at least two allowed sources
    err_mark = errors;
    do begin
      mask = 4'($urandom_range(3, 15));
    end while ($countones(mask) < 2);
    axi_write(clk_switch_pkg::ctrl_addr, {1'b1, 27'd0, mask}, resp);
    wait_status(state_field, {26'd0, clk_switch_pkg::settled, 4'd0},
                "settled after auto write", status);
    exp_idx = expected_sel(1'b1, {4'd0, mask}, stopped);
    check_value("cur_sel", status[2:0], exp_idx, 0);
    measure_period(period);
    check_value("o_clk period", period, src_period_ns(exp_idx), 1);
    // stop the running source until one allowed source is left
    while ($countones(mask & ~stopped) > 1) begin
      idx          = expected_sel(1'b1, {4'd0, mask}, stopped);
      src_en[idx]  = 1'b0;
      stopped[idx] = 1'b1;
      wait_status(fail_field, {20'd0, stopped, 8'd0}, "failure flag", status);
      wait_status(state_field, {26'd0, clk_switch_pkg::settled, 4'd0},
                  "settled after failover", status);
      exp_idx = expected_sel(1'b1, {4'd0, mask}, stopped);
      check_value("cur_sel", status[2:0], exp_idx, 0);
      measure_period(period);
      check_value("o_clk period", period, src_period_ns(exp_idx), 1);
    end
    end_test("auto failover", err_mark);

    // no clock, the last allowed source goes too
    err_mark     = errors;
    idx          = expected_sel(1'b1, {4'd0, mask}, stopped);
    src_en[idx]  = 1'b0;
    stopped[idx] = 1'b1;
    exp_idx      = expected_sel(1'b1, {4'd0, mask}, stopped);
    exp_state    = (exp_idx == no_clk_idx) ? clk_switch_pkg::no_clock :
                                             clk_switch_pkg::settled;
    wait_status(fail_field, {20'd0, stopped, 8'd0}, "failure flag", status);
    wait_status(state_field, {26'd0, exp_state, 4'd0}, "no_clock state", status);
    // sel stays on the dead source
    check_value("cur_sel", status[2:0], idx, 0);
    measure_period(period);
    check_value("o_clk period", period, 0, 0);
    end_test("no clock", err_mark);

    // scan bypass
    err_mark = errors;
    src_en   = '1;
    stopped  = '0;
    wait_status(fail_field, 32'd0, "failure flags clearing", status);
    wait_status(state_field, {26'd0, clk_switch_pkg::settled, 4'd0},
                "settled after recovery", status);
    idx = $urandom_range(0, clk_num - 1);
    axi_write(clk_switch_pkg::ctrl_addr, 32'(idx), resp);
    wait_status(state_field, {26'd0, clk_switch_pkg::settled, 4'd0},
                "settled before scan", status);
    exp_idx = expected_sel(1'b0, 8'(idx), stopped);
    check_value("cur_sel", status[2:0], exp_idx, 0);
    scan_mode = 1'b1;
    measure_period(period);
    check_value("o_clk period scan", period, test_period, 1);
    scan_mode = 1'b0;
    measure_period(period);
    check_value("o_clk period", period, src_period_ns(exp_idx), 1);
    end_test("scan bypass", err_mark);

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // hard stop in case a wait outlives its own limit
  initial begin
    #200000;
    $display("watchdog: run did not finish within 200 us");
    $display("Simulation failed");
    $finish;
  end

endmodule
